// ==== sim.f ====
+incdir+hw
+incdir+sim
hw/mem_tile_pkg.sv
hw/mem_sram_banks.sv
hw/mem_req_decode.sv
hw/mem_atomic_exec.sv
hw/mem_rsp_result.sv
hw/mem_tile_top.sv
sim/tb_mem_tile.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory tile testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_mem_tile -o tb_mem_tile
./obj_dir/tb_mem_tile | tee sim.log

if grep -q "^Everything OK$" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation did not pass"
  exit 1
fi

// ==== sim/mem_tile_tests.svh ====
//////////////////////////////////////////////////////////////////////
// Directed tests: write and read back, byte enables, atomics,
// credit back-pressure and a random mix
//////////////////////////////////////////////////////////////////////

`ifndef MEM_TILE_TESTS_SVH
`define MEM_TILE_TESTS_SVH

  // Word value that depends on every address bit
  function automatic logic [63:0] fill_value(input addr_t addr);
    return {addr ^ 16'h5A5A, ~addr, addr + 16'h1234, addr};
  endfunction

  // Fills every word of both rows, so later reads never see unwritten data
  task automatic test_write_read();
    int    errs;
    addr_t addr;
    errs = err_cnt;
    for (int w = 0; w < NumWords; w++) begin
      addr = addr_t'(w << WordOfs);
      write_word(addr, fill_value(addr), 8'hFF);
    end
    for (int w = NumWords - 1; w >= 0; w--) begin
      read_word(addr_t'(w << WordOfs));
    end
    wait_drain();
    finish_test("write then read", errs);
  endtask

  task automatic test_byte_enables();
    int          errs;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] be;
    errs = err_cnt;
    for (int i = 0; i < NumBe; i++) begin
      a  = take_bits(`MT_ADDR_W);
      d  = take_bits(64);
      be = take_bits(8);
      write_word(a[`MT_ADDR_W-1:0], d, be[7:0]);
      read_word(a[`MT_ADDR_W-1:0]);
    end
    wait_drain();
    finish_test("byte enables", errs);
  endtask

  // Each opcode on both halves, rows alternate with the opcode
  task automatic test_atomics();
    int          errs;
    int          a;
    logic [63:0] operand;
    errs = err_cnt;
    for (int op = 0; op < 4; op++) begin
      for (int half = 0; half < 2; half++) begin
        operand = take_bits(32);
        a = ((op % 2) << `MT_MACRO_SEL_OFS) | ((op * 2 + half) << WordOfs)
            | (half << `MT_AMO_HALF_BIT);
        amo(addr_t'(a), mem_tile_pkg::amo_op_e'(op[1:0]), operand[31:0]);
        read_word(addr_t'(a));
      end
    end
    wait_drain();
    finish_test("atomics", errs);
  endtask

  task automatic test_credits();
    int          errs;
    int          rsp0;
    int          sent0;
    int          crd0;
    logic [63:0] a;
    errs  = err_cnt;
    rsp0  = rsp_cnt;
    sent0 = sent_cnt;
    crd0  = credit_ret_cnt;
    hold_credits = 1'b1;
    for (int i = 0; i < NumBurst; i++) begin
      a = take_bits(`MT_ADDR_W);
      if (i % 2 == 0) begin
        write_word(a[`MT_ADDR_W-1:0], fill_value(a[`MT_ADDR_W-1:0]), 8'hFF);
      end else begin
        read_word(a[`MT_ADDR_W-1:0]);
      end
    end
    go_idle();
    // Observation window with the consumer stalled
    repeat (10 * NumBurst) @(negedge clk);
    assert (rsp_cnt - rsp0 <= `MT_RSP_CREDITS) else begin
      $display("Fail rsp_valid_o count %h above credits %h", rsp_cnt - rsp0, `MT_RSP_CREDITS);
      err_cnt++;
    end
    assert (req_credits == 0) else begin
      $display("Fail req_credit_o credits held %h expected %h", req_credits, 0);
      err_cnt++;
    end
    hold_credits = 1'b0;
    wait_drain();
    assert (credit_ret_cnt - crd0 == sent_cnt - sent0) else begin
      $display("Fail req_credit_o returned %h expected %h",
               credit_ret_cnt - crd0, sent_cnt - sent0);
      err_cnt++;
    end
    finish_test("credits", errs);
  endtask

  // Full 16-bit addresses, so the upper bits exercise aliasing
  task automatic test_random_mix();
    int          errs;
    logic [63:0] k;
    logic [63:0] a;
    logic [63:0] d;
    logic [63:0] r;
    errs = err_cnt;
    for (int i = 0; i < NumRandom; i++) begin
      k = take_bits(2);
      a = take_bits(`MT_ADDR_W);
      if (k[1:0] == 2'd1) begin
        d = take_bits(64);
        r = take_bits(8);
        write_word(a[`MT_ADDR_W-1:0], d, r[7:0]);
      end else if (k[1:0] == 2'd2) begin
        r = take_bits(34);
        amo(a[`MT_ADDR_W-1:0], mem_tile_pkg::amo_op_e'(r[33:32]), r[31:0]);
      end else begin
        read_word(a[`MT_ADDR_W-1:0]);
      end
    end
    wait_drain();
    finish_test("random mix", errs);
  endtask

`endif

// ==== sim/tb_mem_tile.sv ====
//////////////////////////////////////////////////////////////////////
// Memory tile testbench: clock, reset, LFSR, reference memory,
// request driver, response monitor, watchdog and final report
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module tb_mem_tile;

  localparam int ClkPeriod = 40;
  localparam int WordOfs   = `MT_WORD_OFS;
  localparam int UsedAddrW = `MT_MACRO_SEL_OFS + $clog2(`MT_BANK_ROWS);
  localparam int NumWords  = 1 << (UsedAddrW - WordOfs);
  localparam int NumBe     = 8;
  localparam int NumAmo    = 8;
  localparam int NumBurst  = `MT_REQ_DEPTH + `MT_RSP_DEPTH + `MT_RSP_CREDITS;
  localparam int NumRandom = 200;
  localparam int TotalReqs = 2 * NumWords + 2 * NumBe + 2 * NumAmo + NumBurst + NumRandom;

  typedef logic [`MT_ADDR_W-1:0] addr_t;

  logic                   clk;
  logic                   arst_n;
  logic                   req_valid;
  mem_tile_pkg::mem_req_t req;
  logic                   req_credit;
  logic                   rsp_valid;
  mem_tile_pkg::mem_rsp_t rsp;
  logic                   rsp_credit;

  // Requester and consumer bookkeeping
  int req_credits;
  int sent_cnt;
  int credit_ret_cnt;
  int rsp_cnt;
  int pending_credits;
  bit hold_credits;
  int err_cnt;
  int check_cnt;
  int test_cnt;

  logic [31:0]            lfsr_q;
  logic [`MT_ID_W-1:0]    next_id;
  logic [7:0]             ref_mem [1 << UsedAddrW];
  mem_tile_pkg::mem_rsp_t exp_q [$];

  mem_tile_top dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .req_valid_i (req_valid),
    .req_i       (req),
    .req_credit_o(req_credit),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_credit_i(rsp_credit)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
    end
    return v;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference memory, bits above the row select alias
  //////////////////////////////////////////////////////////////////////

  function automatic logic [UsedAddrW-1:0] ref_idx(input addr_t addr, input int b);
    return {addr[UsedAddrW-1:WordOfs], b[WordOfs-1:0]};
  endfunction

  function automatic logic [63:0] ref_word(input addr_t addr);
    logic [63:0] w;
    for (int b = 0; b < 8; b++) begin
      w[b*8 +: 8] = ref_mem[ref_idx(addr, b)];
    end
    return w;
  endfunction

  task automatic ref_write(input addr_t addr, input logic [63:0] data, input logic [7:0] be);
    for (int b = 0; b < 8; b++) begin
      if (be[b]) begin
        ref_mem[ref_idx(addr, b)] = data[b*8 +: 8];
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Request driver
  //////////////////////////////////////////////////////////////////////

  task automatic issue(input mem_tile_pkg::mem_req_t r, input mem_tile_pkg::mem_rsp_t e);
    @(negedge clk);
    while (req_credits == 0) begin
      req_valid = 1'b0;
      @(negedge clk);
    end
    req_valid = 1'b1;
    req       = r;
    req_credits--;
    sent_cnt++;
    exp_q.push_back(e);
  endtask

  task automatic send(input mem_tile_pkg::req_kind_e kind, input addr_t addr,
                      input logic [63:0] data, input logic [7:0] be,
                      input mem_tile_pkg::amo_op_e op, input logic [31:0] operand);
    mem_tile_pkg::mem_req_t r;
    mem_tile_pkg::mem_rsp_t e;
    logic [63:0]            w;
    logic [31:0]            old_v;
    logic [31:0]            new_v;
    logic                   hi;
    r      = '0;
    r.kind = kind;
    r.id   = next_id;
    r.addr = addr;
    w      = ref_word(addr);
    hi     = addr[`MT_AMO_HALF_BIT];
    e.id   = next_id;
    e.kind = kind;
    e.rdata = w;
    if (kind == mem_tile_pkg::REQ_WRITE) begin
      r.payload.data.wdata = data;
      r.payload.data.be    = be;
      ref_write(addr, data, be);
      e.rdata = '0;
    end else if (kind == mem_tile_pkg::REQ_ATOMIC) begin
      r.payload.amo.op      = op;
      r.payload.amo.operand = operand;
      old_v = hi ? w[63:32] : w[31:0];
      case (op)
        mem_tile_pkg::AMO_ADD: new_v = old_v + operand;
        mem_tile_pkg::AMO_AND: new_v = old_v & operand;
        mem_tile_pkg::AMO_OR:  new_v = old_v | operand;
        default:               new_v = operand;
      endcase
      ref_write(addr, {new_v, new_v}, hi ? 8'hF0 : 8'h0F);
      e.rdata = {32'h0, old_v};
    end
    next_id++;
    issue(r, e);
  endtask

  task automatic read_word(input addr_t addr);
    send(mem_tile_pkg::REQ_READ, addr, '0, '0, mem_tile_pkg::AMO_SWAP, '0);
  endtask

  task automatic write_word(input addr_t addr, input logic [63:0] data, input logic [7:0] be);
    send(mem_tile_pkg::REQ_WRITE, addr, data, be, mem_tile_pkg::AMO_SWAP, '0);
  endtask

  task automatic amo(input addr_t addr, input mem_tile_pkg::amo_op_e op,
                     input logic [31:0] operand);
    send(mem_tile_pkg::REQ_ATOMIC, addr, '0, '0, op, operand);
  endtask

  task automatic go_idle();
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  // Waits for every response and every consumer credit to go back
  task automatic wait_drain();
    go_idle();
    while (exp_q.size() != 0 || pending_credits != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("Test %s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Response monitor with credit return
  //////////////////////////////////////////////////////////////////////

  task automatic check_rsp();
    mem_tile_pkg::mem_rsp_t e;
    rsp_cnt++;
    assert (exp_q.size() != 0) else begin
      $display("Response arrived with no request outstanding");
      err_cnt++;
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      check_cnt++;
      assert (rsp.id == e.id) else begin
        $display("Fail rsp_o.id got %h expected %h", rsp.id, e.id);
        err_cnt++;
      end
      assert (rsp.kind == e.kind) else begin
        $display("Fail rsp_o.kind got %h expected %h", rsp.kind, e.kind);
        err_cnt++;
      end
      assert (rsp.rdata == e.rdata) else begin
        $display("Fail rsp_o.rdata got %h expected %h", rsp.rdata, e.rdata);
        err_cnt++;
      end
    end
  endtask

  initial begin
    rsp_credit      = 1'b0;
    pending_credits = 0;
    forever begin
      @(negedge clk);
      if (arst_n) begin
        if (req_credit) begin
          req_credits++;
          credit_ret_cnt++;
        end
        if (rsp_valid) begin
          check_rsp();
          pending_credits++;
        end
        if (!hold_credits && pending_credits > 0) begin
          rsp_credit = 1'b1;
          pending_credits--;
        end else begin
          rsp_credit = 1'b0;
        end
      end
    end
  end

  `include "mem_tile_tests.svh"

  initial begin
    repeat (TotalReqs * 40 + 1000) @(posedge clk);
    $display("Timeout with %0d responses still expected", exp_q.size());
    $display("Something failed");
    $finish;
  end

  initial begin
    arst_n         = 1'b0;
    req_valid      = 1'b0;
    req            = '0;
    req_credits    = `MT_REQ_DEPTH;
    sent_cnt       = 0;
    credit_ret_cnt = 0;
    rsp_cnt        = 0;
    hold_credits   = 1'b0;
    err_cnt        = 0;
    check_cnt      = 0;
    test_cnt       = 0;
    lfsr_q         = 32'd72687;
    next_id        = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    test_write_read();
    test_byte_enables();
    test_atomics();
    test_credits();
    test_random_mix();
    $display("Tests %0d, responses checked %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== hw/mem_tile_top.sv ====
//////////////////////////////////////////////////////////////////////
// Memory tile top: decode, execute and result stages
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module mem_tile_top (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    req_valid_i,
  input  mem_tile_pkg::mem_req_t  req_i,
  output logic                    req_credit_o,
  output logic                    rsp_valid_o,
  output mem_tile_pkg::mem_rsp_t  rsp_o,
  input  logic                    rsp_credit_i
);

  logic                     dec_valid, dec_ready;
  mem_tile_pkg::mem_req_t   dec_req;
  logic [`MT_DATA_W-1:0]    dec_wdata;
  logic [`MT_DATA_W/8-1:0]  dec_be;
  mem_tile_pkg::amo_op_e    dec_amo_op;
  logic [`MT_AMO_W-1:0]     dec_operand;
  logic                     rsv_ok, rsv;
  logic                     exec_valid;
  mem_tile_pkg::mem_rsp_t   exec_rsp;

  mem_req_decode i_req_decode (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_credit_o (req_credit_o),
    .dec_valid_o  (dec_valid),
    .dec_ready_i  (dec_ready),
    .dec_req_o    (dec_req),
    .dec_wdata_o  (dec_wdata),
    .dec_be_o     (dec_be),
    .dec_amo_op_o (dec_amo_op),
    .dec_operand_o(dec_operand)
  );

  mem_atomic_exec i_atomic_exec (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .dec_valid_i  (dec_valid),
    .dec_req_i    (dec_req),
    .dec_wdata_i  (dec_wdata),
    .dec_be_i     (dec_be),
    .dec_amo_op_i (dec_amo_op),
    .dec_operand_i(dec_operand),
    .dec_ready_o  (dec_ready),
    .rsv_ok_i     (rsv_ok),
    .rsv_o        (rsv),
    .exec_valid_o (exec_valid),
    .exec_rsp_o   (exec_rsp)
  );

  mem_rsp_result i_rsp_result (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rsv_i       (rsv),
    .exec_valid_i(exec_valid),
    .exec_rsp_i  (exec_rsp),
    .rsv_ok_o    (rsv_ok),
    .rsp_valid_o (rsp_valid_o),
    .rsp_o       (rsp_o),
    .rsp_credit_i(rsp_credit_i)
  );

endmodule

// ==== hw/mem_rsp_result.sv ====
//////////////////////////////////////////////////////////////////////
// Response result stage: response FIFO, slot reservation toward
// execute and response credit counter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module mem_rsp_result (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic                    rsv_i,
  input  logic                    exec_valid_i,
  input  mem_tile_pkg::mem_rsp_t  exec_rsp_i,
  output logic                    rsv_ok_o,
  output logic                    rsp_valid_o,
  output mem_tile_pkg::mem_rsp_t  rsp_o,
  input  logic                    rsp_credit_i
);

  localparam int unsigned PtrW = $clog2(`MT_RSP_DEPTH);
  localparam int unsigned CntW = $clog2(`MT_RSP_DEPTH + 1);
  localparam int unsigned CrdW = $clog2(`MT_RSP_CREDITS + 1);
  localparam logic [CntW:0] Slots = `MT_RSP_DEPTH;

  mem_tile_pkg::mem_rsp_t fifo_q [`MT_RSP_DEPTH];

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CntW-1:0] rsv_cnt_q;
  logic [CrdW-1:0] credit_q;
  logic [CntW:0]   used;
  logic            pop;

  // Every response in flight owns a slot from issue on
  assign used     = {1'b0, count_q} + {1'b0, rsv_cnt_q};
  assign rsv_ok_o = (used < Slots);

  assign rsp_valid_o = (count_q != '0) && (credit_q != '0);
  assign pop         = rsp_valid_o;
  assign rsp_o       = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (exec_valid_i) begin
      fifo_q[wr_ptr_q] <= exec_rsp_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      rsv_cnt_q <= '0;
      credit_q  <= CrdW'(`MT_RSP_CREDITS);
    end else begin
      if (exec_valid_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`MT_RSP_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`MT_RSP_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q   <= count_q + CntW'(exec_valid_i) - CntW'(pop);
      // Reservation turns into an entry when the response lands
      rsv_cnt_q <= rsv_cnt_q + CntW'(rsv_i) - CntW'(exec_valid_i);
      credit_q  <= credit_q + CrdW'(rsp_credit_i) - CrdW'(pop);
    end
  end

endmodule

// ==== hw/mem_atomic_exec.sv ====
//////////////////////////////////////////////////////////////////////
// Execute stage: read, write and atomic read-modify-write against
// the SRAM banks, response formation
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module mem_atomic_exec (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      dec_valid_i,
  input  mem_tile_pkg::mem_req_t    dec_req_i,
  input  logic [`MT_DATA_W-1:0]     dec_wdata_i,
  input  logic [`MT_DATA_W/8-1:0]   dec_be_i,
  input  mem_tile_pkg::amo_op_e     dec_amo_op_i,
  input  logic [`MT_AMO_W-1:0]      dec_operand_i,
  output logic                      dec_ready_o,
  input  logic                      rsv_ok_i,
  output logic                      rsv_o,
  output logic                      exec_valid_o,
  output mem_tile_pkg::mem_rsp_t    exec_rsp_o
);

  localparam int unsigned AmoBeW = `MT_AMO_W / 8;

  // Access fields from a byte address
  function automatic mem_tile_pkg::sram_acc_t form_acc(
    input logic [`MT_ADDR_W-1:0]   addr,
    input logic                    we,
    input logic [`MT_DATA_W-1:0]   wdata,
    input logic [`MT_DATA_W/8-1:0] be
  );
    mem_tile_pkg::sram_acc_t acc;
    acc.req      = 1'b1;
    acc.we       = we;
    acc.word_idx = addr[`MT_WORD_OFS +: `MT_WORD_IDX_W];
    acc.row_sel  = addr[`MT_MACRO_SEL_OFS +: `MT_ROW_SEL_W];
    acc.wdata    = wdata;
    acc.be       = be;
    return acc;
  endfunction

  mem_tile_pkg::sram_acc_t sram_acc;
  logic [`MT_DATA_W-1:0]   bank_rdata;
  logic                    hs;
  logic                    hs_amo;

  // Atomic in its write phase
  logic                    amo_busy_q;
  mem_tile_pkg::mem_req_t  amo_req_q;
  mem_tile_pkg::amo_op_e   amo_op_q;
  logic [`MT_AMO_W-1:0]    amo_operand_q;
  logic                    amo_hi;
  logic [`MT_AMO_W-1:0]    amo_old, amo_new;
  logic [`MT_DATA_W/8-1:0] amo_be;

  // Response being formed, one cycle behind the final access
  logic                    rsp_valid_q;
  logic [`MT_ID_W-1:0]     rsp_id_q;
  mem_tile_pkg::req_kind_e rsp_kind_q;
  logic [`MT_AMO_W-1:0]    rsp_old_q;

  assign dec_ready_o = rsv_ok_i && !amo_busy_q;
  assign hs          = dec_valid_i && dec_ready_o;
  assign hs_amo      = hs && (dec_req_i.kind == mem_tile_pkg::REQ_ATOMIC);
  assign rsv_o       = hs;

  /////////////////////////////////////////////////////////////////////
  // Atomic execute
  /////////////////////////////////////////////////////////////////////

  assign amo_hi = amo_req_q.addr[`MT_AMO_HALF_BIT];
  assign amo_be = {{AmoBeW{amo_hi}}, {AmoBeW{!amo_hi}}};

  always_comb begin
    amo_old = amo_hi ? bank_rdata[`MT_DATA_W-1 -: `MT_AMO_W] : bank_rdata[`MT_AMO_W-1:0];
    case (amo_op_q)
      mem_tile_pkg::AMO_SWAP: amo_new = amo_operand_q;
      mem_tile_pkg::AMO_ADD:  amo_new = amo_old + amo_operand_q;
      mem_tile_pkg::AMO_AND:  amo_new = amo_old & amo_operand_q;
      mem_tile_pkg::AMO_OR:   amo_new = amo_old | amo_operand_q;
      default:                amo_new = amo_operand_q;
    endcase
  end

  // Write phase of an atomic takes the port ahead of any new request
  always_comb begin
    sram_acc = '0;
    if (amo_busy_q) begin
      sram_acc = form_acc(amo_req_q.addr, 1'b1, {2{amo_new}}, amo_be);
    end else if (hs) begin
      sram_acc = form_acc(dec_req_i.addr, dec_req_i.kind == mem_tile_pkg::REQ_WRITE,
                          dec_wdata_i, dec_be_i);
    end
  end

  mem_sram_banks i_sram_banks (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .acc_i   (sram_acc),
    .rdata_o (bank_rdata)
  );

  /////////////////////////////////////////////////////////////////////
  // In-flight tracking
  /////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      amo_busy_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      amo_busy_q  <= hs_amo;
      rsp_valid_q <= (hs && !hs_amo) || amo_busy_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hs_amo) begin
      amo_req_q     <= dec_req_i;
      amo_op_q      <= dec_amo_op_i;
      amo_operand_q <= dec_operand_i;
    end
    if (amo_busy_q) begin
      rsp_id_q   <= amo_req_q.id;
      rsp_kind_q <= mem_tile_pkg::REQ_ATOMIC;
      rsp_old_q  <= amo_old;
    end else if (hs) begin
      rsp_id_q   <= dec_req_i.id;
      rsp_kind_q <= dec_req_i.kind;
    end
  end

  // Read data comes straight from the banks in the response cycle
  always_comb begin
    exec_rsp_o.id   = rsp_id_q;
    exec_rsp_o.kind = rsp_kind_q;
    case (rsp_kind_q)
      mem_tile_pkg::REQ_READ:   exec_rsp_o.rdata = bank_rdata;
      mem_tile_pkg::REQ_ATOMIC: exec_rsp_o.rdata = {{(`MT_DATA_W-`MT_AMO_W){1'b0}}, rsp_old_q};
      default:                  exec_rsp_o.rdata = '0;
    endcase
  end

  assign exec_valid_o = rsp_valid_q;

endmodule

// ==== hw/mem_req_decode.sv ====
//////////////////////////////////////////////////////////////////////
// Request decode stage: flit FIFO with credit return and payload
// view selection by request kind
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module mem_req_decode (
  input  logic                      clk_i,
  input  logic                      arst_n_i,
  input  logic                      req_valid_i,
  input  mem_tile_pkg::mem_req_t    req_i,
  output logic                      req_credit_o,
  output logic                      dec_valid_o,
  input  logic                      dec_ready_i,
  output mem_tile_pkg::mem_req_t    dec_req_o,
  output logic [`MT_DATA_W-1:0]     dec_wdata_o,
  output logic [`MT_DATA_W/8-1:0]   dec_be_o,
  output mem_tile_pkg::amo_op_e     dec_amo_op_o,
  output logic [`MT_AMO_W-1:0]      dec_operand_o
);

  localparam int unsigned PtrW = $clog2(`MT_REQ_DEPTH);
  localparam int unsigned CntW = $clog2(`MT_REQ_DEPTH + 1);

  mem_tile_pkg::mem_req_t fifo_q [`MT_REQ_DEPTH];
  mem_tile_pkg::mem_req_t head;

  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push, pop;
  logic            credit_q;

  /////////////////////////////////////////////////////////////////////
  // Request FIFO
  /////////////////////////////////////////////////////////////////////

  // Requester holds a credit per free slot, full only on a protocol error
  assign push        = req_valid_i && (count_q != CntW'(`MT_REQ_DEPTH));
  assign dec_valid_o = (count_q != '0);
  assign pop         = dec_valid_o && dec_ready_i;
  assign head        = fifo_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_q <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(`MT_REQ_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(`MT_REQ_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q  <= count_q + CntW'(push) - CntW'(pop);
      // One credit back per popped flit
      credit_q <= pop;
    end
  end

  assign req_credit_o = credit_q;

  /////////////////////////////////////////////////////////////////////
  // Payload decode
  /////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_req_o     = head;
    dec_wdata_o   = '0;
    dec_be_o      = '0;
    dec_amo_op_o  = mem_tile_pkg::AMO_SWAP;
    dec_operand_o = '0;
    case (head.kind)
      mem_tile_pkg::REQ_WRITE: begin
        dec_wdata_o = head.payload.data.wdata;
        dec_be_o    = head.payload.data.be;
      end
      mem_tile_pkg::REQ_ATOMIC: begin
        dec_amo_op_o  = head.payload.amo.op;
        dec_operand_o = head.payload.amo.operand;
      end
      default: begin
      end
    endcase
  end

endmodule

// ==== hw/mem_sram_banks.sv ====
//////////////////////////////////////////////////////////////////////
// Banked SRAM array: bank rows of behavioral macros, macro select
// and registered read row select
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "mem_tile_settings.svh"

module mem_sram_banks (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  mem_tile_pkg::sram_acc_t  acc_i,
  output logic [`MT_DATA_W-1:0]    rdata_o
);

  localparam int unsigned BankBeW = `MT_SRAM_DATA_W / 8;

  logic [`MT_BANK_ROWS-1:0][`MT_BANKS_PER_WORD-1:0][`MT_SRAM_DATA_W-1:0] row_rdata;
  logic [`MT_BANKS_PER_WORD-1:0][`MT_ROW_SEL_W-1:0]                      row_sel_q;

  /////////////////////////////////////////////////////////////////////
  // Read row select
  /////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MT_BANKS_PER_WORD; i++) begin : gen_sel
    // Held across writes so the read data stays steered to its row
    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        row_sel_q[i] <= '0;
      end else if (acc_i.req && !acc_i.we) begin
        row_sel_q[i] <= acc_i.row_sel;
      end
    end

    assign rdata_o[i*`MT_SRAM_DATA_W +: `MT_SRAM_DATA_W] = row_rdata[row_sel_q[i]][i];
  end

  /////////////////////////////////////////////////////////////////////
  // Macros
  /////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `MT_BANKS_PER_WORD; i++) begin : gen_banks
    for (genvar j = 0; j < `MT_BANK_ROWS; j++) begin : gen_rows
      logic [`MT_SRAM_DATA_W-1:0] mem_q [`MT_SRAM_WORDS];
      logic [`MT_SRAM_DATA_W-1:0] rdata_q;
      logic                       en;

      // Only the selected row sees the request
      assign en = acc_i.req && (acc_i.row_sel == `MT_ROW_SEL_W'(j));

      always_ff @(posedge clk_i) begin
        if (en) begin
          if (acc_i.we) begin
            for (int b = 0; b < BankBeW; b++) begin
              if (acc_i.be[i*BankBeW + b]) begin
                mem_q[acc_i.word_idx][b*8 +: 8] <=
                  acc_i.wdata[i*`MT_SRAM_DATA_W + b*8 +: 8];
              end
            end
          end else begin
            rdata_q <= mem_q[acc_i.word_idx];
          end
        end
      end

      assign row_rdata[j][i] = rdata_q;
    end
  end

endmodule

// ==== hw/mem_tile_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Memory tile types: request kind, atomic opcode, payload union,
// request and response flits, SRAM access
//////////////////////////////////////////////////////////////////////

`include "mem_tile_settings.svh"

package mem_tile_pkg;

  typedef enum logic [1:0] {
    REQ_READ   = 2'd0,
    REQ_WRITE  = 2'd1,
    REQ_ATOMIC = 2'd2
  } req_kind_e;

  typedef enum logic [1:0] {
    AMO_SWAP = 2'd0,
    AMO_ADD  = 2'd1,
    AMO_AND  = 2'd2,
    AMO_OR   = 2'd3
  } amo_op_e;

  // Write view of the payload word
  typedef struct packed {
    logic [`MT_DATA_W-1:0]   wdata;
    logic [`MT_DATA_W/8-1:0] be;
  } payload_data_t;

  // Atomic view, padded up to the write view width
  typedef struct packed {
    amo_op_e                                       op;
    logic [`MT_AMO_W-1:0]                          operand;
    logic [`MT_DATA_W+`MT_DATA_W/8-`MT_AMO_W-3:0]  pad;
  } payload_amo_t;

  typedef union packed {
    payload_data_t data;
    payload_amo_t  amo;
  } req_payload_u;

  typedef struct packed {
    req_kind_e             kind;
    logic [`MT_ID_W-1:0]   id;
    logic [`MT_ADDR_W-1:0] addr;
    req_payload_u          payload;
  } mem_req_t;

  typedef struct packed {
    logic [`MT_ID_W-1:0]   id;
    req_kind_e             kind;
    logic [`MT_DATA_W-1:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                      req;
    logic                      we;
    logic [`MT_WORD_IDX_W-1:0] word_idx;
    logic [`MT_ROW_SEL_W-1:0]  row_sel;
    logic [`MT_DATA_W-1:0]     wdata;
    logic [`MT_DATA_W/8-1:0]   be;
  } sram_acc_t;

endpackage

// ==== hw/mem_tile_settings.svh ====
//////////////////////////////////////////////////////////////////////
// Memory tile widths, depths and address bit map
//////////////////////////////////////////////////////////////////////

`ifndef MEM_TILE_SETTINGS_SVH
`define MEM_TILE_SETTINGS_SVH

// Data path
`define MT_ADDR_W          16
`define MT_DATA_W          64
`define MT_SRAM_DATA_W     32
`define MT_AMO_W           32
`define MT_ID_W            4

// SRAM organisation
`define MT_BANKS_PER_WORD  2
`define MT_BANK_ROWS       2
`define MT_SRAM_WORDS      64
`define MT_WORD_IDX_W      6
`define MT_ROW_SEL_W       1

// Address bit map, bits above the row select alias
`define MT_AMO_HALF_BIT    2
`define MT_WORD_OFS        3
`define MT_MACRO_SEL_OFS   9

// Buffering and flow control
`define MT_REQ_DEPTH       4
`define MT_RSP_DEPTH       4
`define MT_RSP_CREDITS     4

`endif
